// ==== Makefile ====
TOP = cpuTb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== design/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
    import cpuPkg::*;
(
    input  word    instr,
    output ctrlSig ctrl,
    output regIdx  rs,
    output regIdx  rt,
    output regIdx  rd,
    output word    imm
);

    opcodeE opcode;
    funcE   func;

    assign opcode = opcodeE'(instr[OPC_MSB:OPC_LSB]);
    assign func   = funcE'(instr[FUNC_MSB:FUNC_LSB]);
    assign rs     = instr[RS_MSB:RS_LSB];
    assign rt     = instr[RT_MSB:RT_LSB];
    assign imm    = {{8{instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};

    always_comb begin
        ctrl = '0;
        rd   = rt;      // I-type destination
        case (opcode)
            OP_RTYPE: begin
                rd         = instr[RD_MSB:RD_LSB];
                ctrl.valid = 1'b1;
                case (func)
                    FN_ADD: begin
                        ctrl.aluOp    = ALU_ADD;
                        ctrl.regWrite = 1'b1;
                    end
                    FN_SUB: begin
                        ctrl.aluOp    = ALU_SUB;
                        ctrl.regWrite = 1'b1;
                    end
                    FN_AND: begin
                        ctrl.aluOp    = ALU_AND;
                        ctrl.regWrite = 1'b1;
                    end
                    FN_ORR: begin
                        ctrl.aluOp    = ALU_OR;
                        ctrl.regWrite = 1'b1;
                    end
                    FN_WWD: begin
                        ctrl.aluOp = ALU_PASSA;   // rs goes out at write-back
                        ctrl.isWwd = 1'b1;
                    end
                    FN_HLT: ctrl.isHalt = 1'b1;
                    default: ctrl = '0;
                endcase
            end
            OP_ADI, OP_LHI, OP_LWD, OP_SWD: begin
                ctrl.valid  = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.aluOp  = (opcode == OP_LHI) ? ALU_LHI : ALU_ADD;
                ctrl.regWrite = (opcode != OP_SWD);
                ctrl.memRead  = (opcode == OP_LWD);
                ctrl.memToReg = (opcode == OP_LWD);
                ctrl.memWrite = (opcode == OP_SWD);
            end
            OP_BNE, OP_BEQ: begin
                ctrl.valid    = 1'b1;
                ctrl.isBranch = 1'b1;
            end
            OP_JMP: begin
                ctrl.valid  = 1'b1;
                ctrl.isJump = 1'b1;
            end
            default: ctrl = '0;  // unknown opcode
        endcase
    end

endmodule

`default_nettype wire

// ==== design/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    typedef logic [15:0] word;
    typedef logic [1:0]  regIdx;

    // instruction word fields
    localparam int OPC_MSB  = 15;
    localparam int OPC_LSB  = 12;
    localparam int RS_MSB   = 11;
    localparam int RS_LSB   = 10;
    localparam int RT_MSB   = 9;
    localparam int RT_LSB   = 8;
    localparam int RD_MSB   = 7;
    localparam int RD_LSB   = 6;
    localparam int FUNC_MSB = 5;
    localparam int FUNC_LSB = 0;
    localparam int IMM_MSB  = 7;
    localparam int IMM_LSB  = 0;
    localparam int JMP_MSB  = 11;   // top bit of the jump target field

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcodeE;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funcE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LHI,    // imm into upper byte
        ALU_PASSA
    } aluOpE;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwdSelE;

    typedef struct packed {
        aluOpE aluOp;
        logic  useImm;
        logic  memRead;
        logic  memWrite;
        logic  regWrite;
        logic  memToReg;
        logic  isWwd;
        logic  isHalt;
        logic  isBranch;
        logic  isJump;
        logic  valid;   // low for a bubble
    } ctrlSig;

    typedef struct packed {
        ctrlSig ctrl;
        regIdx  rs;
        regIdx  rt;
        regIdx  rd;
        word    opA;
        word    opB;
        word    imm;
    } idExReg;

    typedef struct packed {
        ctrlSig ctrl;
        regIdx  rd;
        word    aluResult;
        word    storeData;
    } exMemReg;

    typedef struct packed {
        ctrlSig ctrl;
        regIdx  rd;
        word    aluResult;
        word    loadData;
    } memWbReg;

    typedef struct packed {
        word  addr;
        word  wdata;
        logic write;
    } dmemReq;

    // operand source pick for decode and execute
    function automatic word fwdMux(input fwdSelE sel, input word regVal,
                                   input word exMemVal, input word memWbVal);
        case (sel)
            FWD_EXMEM: return exMemVal;
            FWD_MEMWB: return memWbVal;
            default:   return regVal;
        endcase
    endfunction

    // R-type arithmetic, stores and branches read rt
    function automatic logic readsRt(input ctrlSig c);
        return (c.regWrite && !c.useImm) || c.memWrite || c.isBranch;
    endfunction

endpackage

`default_nettype wire

// ==== design/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage
    import cpuPkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  logic    advance,
    input  idExReg  idEx,
    input  fwdSelE  fwdA,
    input  fwdSelE  fwdB,
    input  word     exMemFwd,
    input  word     memWbFwd,
    output exMemReg exMem
);

    word opA;
    word rtVal;
    word opB;
    word aluResult;

    assign opA   = fwdMux(fwdA, idEx.opA, exMemFwd, memWbFwd);
    assign rtVal = fwdMux(fwdB, idEx.opB, exMemFwd, memWbFwd);   // also store data
    assign opB   = idEx.ctrl.useImm ? idEx.imm : rtVal;

    always_comb begin
        case (idEx.ctrl.aluOp)
            ALU_ADD:   aluResult = opA + opB;
            ALU_SUB:   aluResult = opA - opB;
            ALU_AND:   aluResult = opA & opB;
            ALU_OR:    aluResult = opA | opB;
            ALU_LHI:   aluResult = {opB[7:0], 8'h00};
            ALU_PASSA: aluResult = opA;
            default:   aluResult = opA;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            exMem.ctrl <= '0;
        end else if (advance) begin
            exMem.ctrl      <= idEx.ctrl;
            exMem.rd        <= idEx.rd;
            exMem.aluResult <= aluResult;
            exMem.storeData <= rtVal;
        end
    end

endmodule

`default_nettype wire

// ==== design/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
    import cpuPkg::*;
(
    input  regIdx   idRs,
    input  regIdx   idRt,
    input  logic    idUsesRt,
    input  logic    idIsBranch,
    input  idExReg  idEx,
    input  exMemReg exMem,
    input  memWbReg memWb,
    output logic    stall,
    output fwdSelE  fwdIdA,
    output fwdSelE  fwdIdB,
    output fwdSelE  fwdExA,
    output fwdSelE  fwdExB
);

    logic exWrites;
    logic exLoad;
    logic memWrites;
    logic memLoad;
    logic wbWrites;
    logic idReadsEx;
    logic idReadsMem;

    function automatic fwdSelE pickSrc(input regIdx src, input logic memOk, input logic wbOk,
                                       input regIdx memRd, input regIdx wbRd);
        if (memOk && memRd == src) begin
            return FWD_EXMEM;   // newest producer first
        end else if (wbOk && wbRd == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    assign exWrites  = idEx.ctrl.valid && idEx.ctrl.regWrite;
    assign exLoad    = exWrites && idEx.ctrl.memRead;
    assign memWrites = exMem.ctrl.valid && exMem.ctrl.regWrite;
    assign memLoad   = memWrites && exMem.ctrl.memRead;
    assign wbWrites  = memWb.ctrl.valid && memWb.ctrl.regWrite;

    assign idReadsEx  = (idEx.rd == idRs) || (idUsesRt && idEx.rd == idRt);
    assign idReadsMem = (exMem.rd == idRs) || (idUsesRt && exMem.rd == idRt);

    // branches compare in decode so they wait for ALU results and loads too
    assign stall = (exLoad && idReadsEx) || (idIsBranch && exWrites && idReadsEx)
                 || (idIsBranch && memLoad && idReadsMem);

    // load data not yet back so decode must not take the address
    assign fwdIdA = pickSrc(idRs, memWrites && !memLoad, wbWrites, exMem.rd, memWb.rd);
    assign fwdIdB = pickSrc(idRt, memWrites && !memLoad, wbWrites, exMem.rd, memWb.rd);
    assign fwdExA = pickSrc(idEx.rs, memWrites, wbWrites, exMem.rd, memWb.rd);
    assign fwdExB = pickSrc(idEx.rt, memWrites, wbWrites, exMem.rd, memWb.rd);

    always_comb begin
        // load-use stall a cycle earlier keeps loads out of the EX forward path
        assert final (!(idEx.ctrl.valid && memLoad
                        && ((fwdExA == FWD_EXMEM)
                            || (readsRt(idEx.ctrl) && fwdExB == FWD_EXMEM))))
            else $error("execute forward from load in MEM");
    end

endmodule

`default_nettype wire

// ==== design/pipelineCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu
    import cpuPkg::*;
#(
    parameter word resetPc = 16'h0000
) (
    input  logic           clk,
    input  logic           reset_n,
    output word            instAddr,
    input  word            instData,
    output logic           dmemValid,
    output cpuPkg::dmemReq dmemReq,
    input  logic           dmemReady,
    input  word            dmemRdata,
    output logic           wwdValid,
    output word            outputPort,
    output word            numInst,
    output logic           halted
);

    word     pc;
    word     ifIdInstr;
    word     ifIdPc;
    logic    ifIdValid;
    logic    haltPending;

    ctrlSig  decCtrl;
    ctrlSig  idCtrl;
    regIdx   idRs;
    regIdx   idRt;
    regIdx   idRd;
    word     idImm;
    word     rfA;
    word     rfB;
    word     idA;
    word     idB;
    logic    idUsesRt;

    logic    stall;
    fwdSelE  fwdIdA;
    fwdSelE  fwdIdB;
    fwdSelE  fwdExA;
    fwdSelE  fwdExB;

    word     pcPlus1;
    word     target;
    logic    takeBranch;
    logic    redirect;
    logic    fetchStop;

    idExReg  idEx;
    exMemReg exMem;
    memWbReg memWb;
    word     wbData;
    logic    advance;
    logic    retire;

    controlDecoder u_controlDecoder (
        .instr (ifIdInstr),
        .ctrl  (decCtrl),
        .rs    (idRs),
        .rt    (idRt),
        .rd    (idRd),
        .imm   (idImm)
    );

    assign idCtrl   = ifIdValid ? decCtrl : '0;    // flushed slot
    assign idUsesRt = readsRt(idCtrl);

    regFile u_regFile (
        .clk     (clk),
        .reset_n (reset_n),
        .rdAddrA (idRs),
        .rdAddrB (idRt),
        .rdDataA (rfA),
        .rdDataB (rfB),
        .wrEn    (memWb.ctrl.valid && memWb.ctrl.regWrite),
        .wrAddr  (memWb.rd),
        .wrData  (wbData)
    );

    hazardUnit u_hazardUnit (
        .idRs       (idRs),
        .idRt       (idRt),
        .idUsesRt   (idUsesRt),
        .idIsBranch (idCtrl.isBranch),
        .idEx       (idEx),
        .exMem      (exMem),
        .memWb      (memWb),
        .stall      (stall),
        .fwdIdA     (fwdIdA),
        .fwdIdB     (fwdIdB),
        .fwdExA     (fwdExA),
        .fwdExB     (fwdExB)
    );

    executeStage u_executeStage (
        .clk      (clk),
        .reset_n  (reset_n),
        .advance  (advance),
        .idEx     (idEx),
        .fwdA     (fwdExA),
        .fwdB     (fwdExB),
        .exMemFwd (exMem.aluResult),
        .memWbFwd (wbData),
        .exMem    (exMem)
    );

    // branch resolution in decode
    assign idA        = fwdMux(fwdIdA, rfA, exMem.aluResult, wbData);
    assign idB        = fwdMux(fwdIdB, rfB, exMem.aluResult, wbData);
    assign pcPlus1    = ifIdPc + 16'd1;
    assign takeBranch = (opcodeE'(ifIdInstr[OPC_MSB:OPC_LSB]) == OP_BNE) ? (idA != idB)
                                                                          : (idA == idB);
    assign target     = idCtrl.isJump ? {ifIdPc[15:12], ifIdInstr[JMP_MSB:0]}
                                      : pcPlus1 + idImm;
    assign redirect   = idCtrl.isJump || (idCtrl.isBranch && takeBranch);
    assign fetchStop  = haltPending || idCtrl.isHalt;

    // everything freezes while the data access in MEM waits
    assign dmemValid = exMem.ctrl.valid && (exMem.ctrl.memRead || exMem.ctrl.memWrite);
    assign dmemReq   = '{addr: exMem.aluResult, wdata: exMem.storeData,
                         write: exMem.ctrl.memWrite};
    assign advance   = !(dmemValid && !dmemReady);

    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc          <= resetPc;
            ifIdValid   <= 1'b0;
            haltPending <= 1'b0;
        end else if (advance && !stall) begin
            if (idCtrl.isHalt) begin
                haltPending <= 1'b1;
            end
            if (fetchStop) begin
                ifIdValid <= 1'b0;  // pc holds from here on
            end else if (redirect) begin
                pc        <= target;
                ifIdValid <= 1'b0;
            end else begin
                pc        <= pc + 16'd1;
                ifIdValid <= 1'b1;
                ifIdInstr <= instData;
                ifIdPc    <= pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            idEx.ctrl <= '0;
        end else if (advance) begin
            if (stall) begin
                idEx.ctrl <= '0;    // bubble into EX
            end else begin
                idEx <= '{ctrl: idCtrl, rs: idRs, rt: idRt, rd: idRd,
                          opA: idA, opB: idB, imm: idImm};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            memWb.ctrl <= '0;
        end else if (advance) begin
            memWb.ctrl      <= exMem.ctrl;
            memWb.rd        <= exMem.rd;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= dmemRdata;
        end
    end

    assign wbData     = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluResult;
    assign retire     = advance && memWb.ctrl.valid;
    assign wwdValid   = retire && memWb.ctrl.isWwd;
    assign outputPort = memWb.aluResult;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            numInst <= '0;
            halted  <= 1'b0;
        end else if (retire) begin
            numInst <= numInst + 16'd1;
            if (memWb.ctrl.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    // request held steady until accepted
    assert property (@(posedge clk) disable iff (reset_n)
        dmemValid && !dmemReady |=> dmemValid && $stable(dmemReq))
        else $error("data request changed while waiting");

    // only bubbles drain after HLT
    assert property (@(posedge clk) disable iff (reset_n) halted |-> !wwdValid)
        else $error("output after halt");

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  regIdx rdAddrA,
    input  regIdx rdAddrB,
    output word   rdDataA,
    output word   rdDataB,
    input  logic  wrEn,
    input  regIdx wrAddr,
    input  word   wrData
);

    word regs [4];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-back value shows through in the same cycle
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    input  logic resetReq,
    output logic clk,
    output logic reset_n
);

    logic startRst;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        startRst = 1'b1;
        repeat (16) @(posedge clk);
        #1 startRst = 1'b0;
    end

    assign reset_n = startRst || resetReq;  // active high

endmodule

`default_nettype wire

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb
    import cpuPkg::*;
;

    logic   clk;
    logic   reset_n;
    logic   resetReq;
    word    instAddr;
    word    instData;
    logic   dmemValid;
    dmemReq dataReq;
    logic   dmemReady;
    word    dmemRdata;
    logic   wwdValid;
    word    outputPort;
    word    numInst;
    logic   halted;

    word refImem [256];
    word refDmem [256];
    word expOut [$];
    int  refCount;
    int  outIdx;
    bit  checking;
    int  failCount;
    int  cycles;
    int  cycleLimit;
    int  total;

    clockGen u_clockGen (.resetReq(resetReq), .clk(clk), .reset_n(reset_n));

    memModel u_memModel (
        .clk       (clk),
        .reset_n   (reset_n),
        .instAddr  (instAddr),
        .instData  (instData),
        .dmemValid (dmemValid),
        .req       (dataReq),
        .dmemReady (dmemReady),
        .dmemRdata (dmemRdata)
    );

    pipelineCpu #(.resetPc(16'h0000)) i_pipelineCpu (
        .clk        (clk),
        .reset_n    (reset_n),
        .instAddr   (instAddr),
        .instData   (instData),
        .dmemValid  (dmemValid),
        .dmemReq    (dataReq),
        .dmemReady  (dmemReady),
        .dmemRdata  (dmemRdata),
        .wwdValid   (wwdValid),
        .outputPort (outputPort),
        .numInst    (numInst),
        .halted     (halted)
    );

    task automatic reportFailure(input string msg);
        failCount++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input word got, input word exp);
        if (got !== exp) begin
            reportFailure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkCount(input word got, input word exp);
        if (got !== exp) begin
            reportFailure($sformatf("Mismatch numInst: got %h expected %h", got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic word rIns(funcE fn, regIdx rs, regIdx rt, regIdx rd);
        return {OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic word iIns(opcodeE op, regIdx rs, regIdx rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ISA model stepping one instruction at a time on plain arrays
    function automatic void isaRun();
        word   r [4];
        word   pc;
        word   curPc;
        word   ins;
        word   immS;
        word   ea;
        regIdx rs;
        regIdx rt;
        regIdx rd;
        r = '{default: '0};
        pc = '0;
        expOut.delete();
        refCount = 0;
        while (refCount < 1000) begin
            curPc = pc;
            ins   = refImem[pc[7:0]];
            rs    = ins[11:10];
            rt    = ins[9:8];
            rd    = ins[7:6];
            immS  = {{8{ins[7]}}, ins[7:0]};
            ea    = r[rs] + immS;
            pc    = pc + 16'd1;
            refCount++;
            case (ins[15:12])
                4'd15: begin
                    case (ins[5:0])
                        6'd0: r[rd] = r[rs] + r[rt];
                        6'd1: r[rd] = r[rs] - r[rt];
                        6'd2: r[rd] = r[rs] & r[rt];
                        6'd3: r[rd] = r[rs] | r[rt];
                        6'd28: expOut.push_back(r[rs]);
                        6'd29: return;
                        default: ;
                    endcase
                end
                4'd4: r[rt] = ea;
                4'd6: r[rt] = {ins[7:0], 8'h00};
                4'd7: r[rt] = refDmem[ea[7:0]];
                4'd8: refDmem[ea[7:0]] = r[rt];
                4'd0: if (r[rs] != r[rt]) pc = pc + immS;
                4'd1: if (r[rs] == r[rt]) pc = pc + immS;
                4'd9: pc = {curPc[15:12], ins[11:0]};
                default: ;
            endcase
        end
    endfunction

    task automatic buildProgram(input int id);
        word p [$];
        case (id)
            1: p = '{iIns(OP_ADI, 0, 1, 8'd5), iIns(OP_ADI, 1, 2, 8'd3),
                     rIns(FN_ADD, 1, 2, 3), rIns(FN_SUB, 3, 1, 0),
                     rIns(FN_AND, 3, 0, 1), rIns(FN_ORR, 1, 3, 2),
                     iIns(OP_LHI, 0, 3, 8'h12), rIns(FN_ADD, 3, 2, 0),
                     rIns(FN_WWD, 0, 0, 0), rIns(FN_WWD, 1, 0, 0),
                     rIns(FN_WWD, 2, 0, 0), rIns(FN_WWD, 3, 0, 0),
                     rIns(FN_HLT, 0, 0, 0)};
            2: p = '{iIns(OP_ADI, 0, 1, 8'h10), iIns(OP_ADI, 0, 2, 8'h7f),
                     iIns(OP_SWD, 1, 2, 8'd0), iIns(OP_SWD, 1, 1, 8'd1),
                     iIns(OP_LWD, 1, 3, 8'd0), rIns(FN_WWD, 3, 0, 0),
                     iIns(OP_LWD, 1, 0, 8'd1), rIns(FN_ADD, 0, 3, 2),
                     rIns(FN_WWD, 2, 0, 0), iIns(OP_SWD, 1, 2, 8'hfe),
                     iIns(OP_LWD, 1, 3, 8'd5), rIns(FN_WWD, 3, 0, 0),
                     rIns(FN_HLT, 0, 0, 0)};
            3: p = '{iIns(OP_ADI, 0, 1, 8'h20), iIns(OP_ADI, 0, 2, 8'd9),
                     iIns(OP_SWD, 1, 2, 8'd0), iIns(OP_LWD, 1, 3, 8'd0),
                     rIns(FN_ADD, 3, 3, 0), rIns(FN_WWD, 0, 0, 0),
                     iIns(OP_LWD, 1, 3, 8'd0), iIns(OP_BEQ, 3, 2, 8'd1),
                     rIns(FN_WWD, 1, 0, 0), rIns(FN_WWD, 3, 0, 0),
                     iIns(OP_LWD, 1, 0, 8'd1), iIns(OP_BNE, 0, 3, 8'd1),
                     rIns(FN_WWD, 2, 0, 0), rIns(FN_HLT, 0, 0, 0)};
            default: p = '{iIns(OP_ADI, 0, 1, 8'd1), iIns(OP_ADI, 0, 2, 8'd1),
                     iIns(OP_BEQ, 1, 2, 8'd2), rIns(FN_WWD, 1, 0, 0),
                     rIns(FN_WWD, 2, 0, 0), iIns(OP_BNE, 1, 2, 8'd1),
                     iIns(OP_ADI, 0, 3, 8'h33), rIns(FN_WWD, 3, 0, 0),
                     {OP_JMP, 12'd11}, rIns(FN_WWD, 1, 0, 0),
                     rIns(FN_WWD, 1, 0, 0), iIns(OP_BNE, 1, 3, 8'd1),
                     rIns(FN_WWD, 3, 0, 0), iIns(OP_BEQ, 1, 3, 8'd1),
                     rIns(FN_WWD, 1, 0, 0), rIns(FN_HLT, 0, 0, 0)};
        endcase
        for (int a = 0; a < 256; a++) begin
            refImem[a] = (a < p.size()) ? p[a] : '0;
            refDmem[a] = {a[7:0], ~a[7:0]} ^ 16'h3c5a;   // per-address fill
        end
    endtask

    task automatic prepare(input int id, input bit toDut);
        buildProgram(id);
        if (toDut) begin
            for (int a = 0; a < 256; a++) begin
                u_memModel.writeInst(a, refImem[a]);
                u_memModel.writeData(a, refDmem[a]);
            end
        end
        isaRun();
    endtask

    // holds reset while the next program goes in and checks the cleared state
    task automatic resetDut(input int id);
        @(posedge clk);
        #1 resetReq = 1'b1;
        prepare(id, 1'b1);
        repeat (16) @(posedge clk);
        @(negedge clk);
        checkBit("halted", halted, 1'b0);
        checkBit("wwdValid", wwdValid, 1'b0);
        checkCount(numInst, '0);
        @(posedge clk);
        #1 resetReq = 1'b0;
    endtask

    task automatic runProgram(input int id);
        word count;
        resetDut(id);
        outIdx   = 0;
        checking = 1'b1;
        while (!halted) @(negedge clk);
        count = 16'(refCount);
        checkCount(numInst, count);
        repeat (10) @(negedge clk);
        checkBit("halted", halted, 1'b1);
        checkCount(numInst, count);
        if (outIdx != expOut.size()) begin
            reportFailure($sformatf("program %0d gave %0d outputs, model gave %0d",
                                    id, outIdx, expOut.size()));
        end
        checking = 1'b0;
        for (int a = 0; a < 256; a++) begin
            checkWord($sformatf("dmem[%0d]", a), u_memModel.peekData(a), refDmem[a]);
        end
    endtask

    always @(negedge clk) begin
        if (checking && wwdValid) begin
            if (outIdx >= expOut.size()) begin
                reportFailure("wwdValid pulsed with no output left in the model");
            end else begin
                checkWord("outputPort", outputPort, expOut[outIdx]);
                outIdx++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit != 0 && cycles > cycleLimit) begin
            reportFailure($sformatf("timeout after %0d cycles", cycles));
        end
    end

    initial begin
        void'($urandom(32'h75b1_7e9e));
        resetReq   = 1'b0;
        checking   = 1'b0;
        failCount  = 0;
        cycles     = 0;
        cycleLimit = 0;
        total      = 0;
        for (int id = 1; id <= 4; id++) begin
            prepare(id, 1'b0);
            total += refCount;
        end
        cycleLimit = 20 * total + 250;  // reset and settle time on top
        runProgram(1);
        runProgram(2);
        resetDut(4);
        repeat (8) @(posedge clk);  // program 4 cut short by the next reset
        runProgram(3);
        runProgram(4);
        if (failCount == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            reportFailure("checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== tb/memModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module memModel
    import cpuPkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  word    instAddr,
    output word    instData,
    input  logic   dmemValid,
    input  dmemReq req,
    output logic   dmemReady,
    output word    dmemRdata
);

    word imem [256];
    word dmem [256];
    logic [2:0] waitCnt;    // cycles left before ready

    assign instData  = imem[instAddr[7:0]];
    assign dmemReady = dmemValid && (waitCnt == 3'd0);
    assign dmemRdata = dmem[req.addr[7:0]];

    always @(posedge clk) begin
        if (reset_n) begin
            waitCnt <= 3'd0;
        end else if (dmemValid) begin
            if (waitCnt == 3'd0) begin
                waitCnt <= 3'($urandom % 4);   // delay for the next request
                if (req.write) begin
                    dmem[req.addr[7:0]] <= req.wdata;
                end
            end else begin
                waitCnt <= waitCnt - 3'd1;
            end
        end
    end

    task automatic writeInst(input int addr, input word value);
        imem[addr] = value;
    endtask

    task automatic writeData(input int addr, input word value);
        dmem[addr] = value;
    endtask

    function automatic word peekData(input int addr);
        return dmem[addr];
    endfunction

endmodule

`default_nettype wire

// ==== vlog.f ====
design/cpuPkg.sv
design/controlDecoder.sv
design/regFile.sv
design/hazardUnit.sv
design/executeStage.sv
design/pipelineCpu.sv
tb/clockGen.sv
tb/memModel.sv
tb/cpuTb.sv
